//--- common/rob_pkg.sv
package rob_pkg;

    // register values and branch targets
    localparam int DATA_W = 32;

    // architectural register name
    localparam int REG_W = 5;

    // size of the architectural register file
    localparam int NUM_REGS = 1 << REG_W;

    // retire behaviour of a buffer entry
    //   OP_ALU     writes rd once its result is in
    //   OP_STORE   no rd write, leaves the head on store_done
    //   OP_BRANCH  writes rd (x0 allowed), checked against its prediction
    typedef enum logic [1:0] {
        OP_ALU    = 2'd0,
        OP_STORE  = 2'd1,
        OP_BRANCH = 2'd2
    } op_t;

endpackage

//--- rob/rob.sv
module rob
    import rob_pkg::*;
#(
    parameter int NICK_W = 5
) (
    input  logic              clk,
    input  logic              rst,

    input  logic              alloc_en,
    input  logic [REG_W-1:0]  alloc_rd,
    input  op_t               alloc_op,
    input  logic              alloc_pred,
    output logic              alloc_ok,
    output logic [NICK_W-1:0] alloc_nick,
    output logic              full,

    input  logic              ex_en,
    input  logic [NICK_W-1:0] ex_nick,
    input  logic [DATA_W-1:0] ex_data,
    input  logic              ex_taken,
    input  logic [DATA_W-1:0] ex_target,

    output logic              commit_en,
    output logic [REG_W-1:0]  commit_rd,
    output logic [DATA_W-1:0] commit_data,
    output logic [NICK_W-1:0] commit_nick,

    output logic              store_go,
    output logic [NICK_W-1:0] store_nick,
    input  logic              store_done,

    output logic              flush,
    output logic [DATA_W-1:0] redirect_pc
);

    // nick 0 means no producer, entries live at 1..DEPTH
    localparam int DEPTH = (1 << NICK_W) - 1;
    localparam logic [NICK_W-1:0] FIRST_NICK = NICK_W'(1);
    localparam logic [NICK_W-1:0] LAST_NICK  = NICK_W'(DEPTH);

    logic [DEPTH:1]    occupied;
    logic [DEPTH:1]    done;

    op_t               op_q     [1:DEPTH];
    logic [REG_W-1:0]  rd_q     [1:DEPTH];
    logic              pred_q   [1:DEPTH];
    logic [DATA_W-1:0] data_q   [1:DEPTH];
    logic              taken_q  [1:DEPTH];
    logic [DATA_W-1:0] target_q [1:DEPTH];

    logic [NICK_W-1:0] wr_ptr;
    logic [NICK_W-1:0] rd_ptr;

    logic head_valid;
    logic head_store;
    logic retire;

    function automatic logic [NICK_W-1:0] next_nick(input logic [NICK_W-1:0] nick);
        if (nick == LAST_NICK) begin
            return FIRST_NICK;
        end
        return nick + NICK_W'(1);
    endfunction

    // issue side
    assign full       = &occupied;
    assign alloc_ok   = alloc_en && !full;
    assign alloc_nick = wr_ptr;

    // head decode
    assign head_valid = occupied[rd_ptr];
    assign head_store = head_valid && (op_q[rd_ptr] == OP_STORE);

    // a store never commits to the register file, it waits for the memory side
    assign commit_en   = head_valid && done[rd_ptr] && !head_store;
    assign commit_rd   = rd_q[rd_ptr];
    assign commit_data = data_q[rd_ptr];
    assign commit_nick = rd_ptr;

    assign store_go   = head_store;
    assign store_nick = rd_ptr;

    // mispredicted branch at the head
    assign flush = commit_en && (op_q[rd_ptr] == OP_BRANCH)
                   && (taken_q[rd_ptr] != pred_q[rd_ptr]);
    assign redirect_pc = target_q[rd_ptr];

    assign retire = commit_en || (head_store && store_done);

    always_ff @(posedge clk) begin
        if (rst) begin
            occupied <= '0;
            done     <= '0;
            wr_ptr   <= FIRST_NICK;
            rd_ptr   <= FIRST_NICK;
        end else if (flush) begin
            // everything younger than the branch is dropped
            occupied <= '0;
            done     <= '0;
            wr_ptr   <= FIRST_NICK;
            rd_ptr   <= FIRST_NICK;
        end else begin
            if (alloc_ok) begin
                occupied[wr_ptr] <= 1'b1;
                done[wr_ptr]     <= 1'b0;
                wr_ptr           <= next_nick(wr_ptr);
            end
            if (ex_en) begin
                done[ex_nick] <= 1'b1;
            end
            // the retiring slot is occupied, so it never collides with the new one
            if (retire) begin
                occupied[rd_ptr] <= 1'b0;
                done[rd_ptr]     <= 1'b0;
                rd_ptr           <= next_nick(rd_ptr);
            end
        end
    end

    // entry payload
    always_ff @(posedge clk) begin
        if (alloc_ok) begin
            op_q[wr_ptr]   <= alloc_op;
            rd_q[wr_ptr]   <= alloc_rd;
            pred_q[wr_ptr] <= alloc_pred;
        end
        if (ex_en) begin
            data_q[ex_nick]   <= ex_data;
            taken_q[ex_nick]  <= ex_taken;
            target_q[ex_nick] <= ex_target;
        end
    end

    // execute units only report on live entries
    ex_to_live_entry: assert property (
        @(posedge clk) disable iff (rst)
        ex_en |-> (ex_nick != '0) && occupied[ex_nick]
    ) else $error("ex_en to unoccupied nick %0d", ex_nick);

    // memory side answers only a released store
    store_done_in_window: assert property (
        @(posedge clk) disable iff (rst)
        store_done |-> store_go
    ) else $error("store_done without a pending store");

    // flush commits the branch, then the buffer restarts empty at nick 1
    flush_restart: assert property (
        @(posedge clk) disable iff (rst)
        flush |-> commit_en ##1 (alloc_nick == FIRST_NICK && !commit_en && !store_go)
    ) else $error("buffer not empty after flush");

endmodule

//--- source/rename_regfile.sv
module rename_regfile
    import rob_pkg::*;
#(
    parameter int NICK_W = 5
) (
    input  logic              clk,
    input  logic              rst,

    // new producer from the issue side
    input  logic              alloc_ok,
    input  logic [REG_W-1:0]  alloc_rd,
    input  logic [NICK_W-1:0] alloc_nick,

    // retirement write
    input  logic              commit_en,
    input  logic [REG_W-1:0]  commit_rd,
    input  logic [DATA_W-1:0] commit_data,
    input  logic [NICK_W-1:0] commit_nick,

    input  logic              flush,

    input  logic [REG_W-1:0]  rd_addr,
    output logic [DATA_W-1:0] rd_data,
    output logic              rd_busy,
    output logic [NICK_W-1:0] rd_tag
);

    logic [DATA_W-1:0] regs [NUM_REGS];
    logic [NICK_W-1:0] tags [NUM_REGS];

    logic commit_wr;
    logic alloc_wr;

    // x0 is never written and never renamed
    assign commit_wr = commit_en && (commit_rd != '0);
    assign alloc_wr  = alloc_ok && (alloc_rd != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (commit_wr) begin
            regs[commit_rd] <= commit_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                tags[i] <= '0;
            end
        end else begin
            // only the latest producer may release the register
            if (commit_wr && (tags[commit_rd] == commit_nick)) begin
                tags[commit_rd] <= '0;
            end
            // a same-cycle allocation overrides the release above
            if (alloc_wr) begin
                tags[alloc_rd] <= alloc_nick;
            end
        end
    end

    assign rd_data = (rd_addr == '0) ? '0 : regs[rd_addr];
    assign rd_tag  = tags[rd_addr];
    assign rd_busy = (rd_tag != '0);

    x0_never_tagged: assert property (
        @(posedge clk) disable iff (rst)
        tags[0] == '0
    ) else $error("x0 holds producer tag %0d", tags[0]);

endmodule

//--- source/rob_top.sv
module rob_top
    import rob_pkg::*;
#(
    parameter int NICK_W = 5
) (
    input  logic              clk,
    input  logic              rst,

    input  logic              alloc_en,
    input  logic [REG_W-1:0]  alloc_rd,
    input  op_t               alloc_op,
    input  logic              alloc_pred,
    output logic              alloc_ok,
    output logic [NICK_W-1:0] alloc_nick,
    output logic              full,

    input  logic              ex_en,
    input  logic [NICK_W-1:0] ex_nick,
    input  logic [DATA_W-1:0] ex_data,
    input  logic              ex_taken,
    input  logic [DATA_W-1:0] ex_target,

    output logic              store_go,
    output logic [NICK_W-1:0] store_nick,
    input  logic              store_done,

    output logic              flush,
    output logic [DATA_W-1:0] redirect_pc,

    input  logic [REG_W-1:0]  rd_addr,
    output logic [DATA_W-1:0] rd_data,
    output logic              rd_busy,
    output logic [NICK_W-1:0] rd_tag,

    // retirement, visible for observation
    output logic              commit_en,
    output logic [NICK_W-1:0] commit_nick
);

    logic [REG_W-1:0]  commit_rd;
    logic [DATA_W-1:0] commit_data;

    rob #(
        .NICK_W(NICK_W)
    ) u_rob (
        .clk        (clk),
        .rst        (rst),
        .alloc_en   (alloc_en),
        .alloc_rd   (alloc_rd),
        .alloc_op   (alloc_op),
        .alloc_pred (alloc_pred),
        .alloc_ok   (alloc_ok),
        .alloc_nick (alloc_nick),
        .full       (full),
        .ex_en      (ex_en),
        .ex_nick    (ex_nick),
        .ex_data    (ex_data),
        .ex_taken   (ex_taken),
        .ex_target  (ex_target),
        .commit_en  (commit_en),
        .commit_rd  (commit_rd),
        .commit_data(commit_data),
        .commit_nick(commit_nick),
        .store_go   (store_go),
        .store_nick (store_nick),
        .store_done (store_done),
        .flush      (flush),
        .redirect_pc(redirect_pc)
    );

    rename_regfile #(
        .NICK_W(NICK_W)
    ) u_rename_regfile (
        .clk        (clk),
        .rst        (rst),
        .alloc_ok   (alloc_ok),
        .alloc_rd   (alloc_rd),
        .alloc_nick (alloc_nick),
        .commit_en  (commit_en),
        .commit_rd  (commit_rd),
        .commit_data(commit_data),
        .commit_nick(commit_nick),
        .flush      (flush),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .rd_busy    (rd_busy),
        .rd_tag     (rd_tag)
    );

endmodule

//--- verif/tb_rob_top.sv
module tb_rob_top
    import rob_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NICK_W = 3;
    localparam STIM_FILE = "verif/rob_stim.txt";

    logic              clk;
    logic              rst;
    logic              alloc_en;
    logic [REG_W-1:0]  alloc_rd;
    op_t               alloc_op;
    logic              alloc_pred;
    logic              alloc_ok;
    logic [NICK_W-1:0] alloc_nick;
    logic              full;
    logic              ex_en;
    logic [NICK_W-1:0] ex_nick;
    logic [DATA_W-1:0] ex_data;
    logic              ex_taken;
    logic [DATA_W-1:0] ex_target;
    logic              store_go;
    logic [NICK_W-1:0] store_nick;
    logic              store_done;
    logic              flush;
    logic [DATA_W-1:0] redirect_pc;
    logic [REG_W-1:0]  rd_addr;
    logic [DATA_W-1:0] rd_data;
    logic              rd_busy;
    logic [NICK_W-1:0] rd_tag;
    logic              commit_en;
    logic [NICK_W-1:0] commit_nick;

    int                seed;
    int                cycles;
    int                cycle_limit;
    int                step;
    int                fd;
    int                code;
    logic [8*16-1:0]   cmd;
    logic [8*256-1:0]  text;
    logic [DATA_W-1:0] fld [5];

    rob_top #(
        .NICK_W(NICK_W)
    ) UUT (
        .*
    );

    always #5 clk = ~clk;

    // stimulus length sets the limit
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            abort_run($sformatf("timeout after %0d cycles, stimulus did not finish", cycles));
        end
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test failures found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [DATA_W-1:0] expected,
                               input logic [DATA_W-1:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("[ERROR] %s expected %0h actual %0h", name, expected, actual));
        end
    endtask

    function automatic string check_name(input string sig);
        return $sformatf("step %0d %0s %s", step, cmd, sig);
    endfunction

    task automatic drive_idle();
        alloc_en   = 1'b0;
        alloc_rd   = '0;
        alloc_op   = OP_ALU;
        alloc_pred = 1'b0;
        ex_en      = 1'b0;
        ex_nick    = '0;
        // junk payload, ignored while ex_en is low
        ex_data    = $random(seed);
        ex_taken   = 1'b0;
        ex_target  = '0;
        store_done = 1'b0;
    endtask

    // one clock, back at the falling edge with inputs idle
    task automatic next_cycle();
        @(posedge clk);
        @(negedge clk);
        drive_idle();
        #0.2;
    endtask

    task automatic run_command();
        case (cmd)
            "alloc": begin
                alloc_en   = 1'b1;
                alloc_rd   = fld[0][REG_W-1:0];
                alloc_op   = op_t'(fld[1][1:0]);
                alloc_pred = fld[2][0];
                #0.2;
                check_value(check_name("alloc_nick"), fld[3], alloc_nick);
                check_value(check_name("alloc_ok"), fld[4], alloc_ok);
                // refused only when the buffer is full
                check_value(check_name("full"), !fld[4][0], full);
                next_cycle();
            end
            "exec": begin
                ex_en     = 1'b1;
                ex_nick   = fld[0][NICK_W-1:0];
                ex_data   = fld[1];
                ex_taken  = fld[2][0];
                ex_target = fld[3];
                next_cycle();
            end
            "sdone": begin
                check_value(check_name("store_go"), 1, store_go);
                check_value(check_name("store_nick"), fld[0], store_nick);
                store_done = 1'b1;
                next_cycle();
            end
            "idle": begin
                next_cycle();
            end
            "chk_commit": begin
                check_value(check_name("commit_en"), fld[0], commit_en);
                if (fld[0][0]) begin
                    check_value(check_name("commit_nick"), fld[1], commit_nick);
                    check_value(check_name("commit_data"), fld[2], UUT.commit_data);
                end
            end
            "chk_flush": begin
                check_value(check_name("flush"), fld[0], flush);
                if (fld[0][0]) begin
                    check_value(check_name("redirect_pc"), fld[1], redirect_pc);
                end
            end
            "chk_reg": begin
                rd_addr = fld[0][REG_W-1:0];
                #0.2;
                check_value(check_name("rd_data"), fld[1], rd_data);
                check_value(check_name("rd_busy"), fld[2], rd_busy);
                check_value(check_name("rd_tag"), fld[3], rd_tag);
            end
            default: begin
                abort_run($sformatf("unknown stimulus command %0s", cmd));
            end
        endcase
    endtask

    initial begin
        seed        = 32'hcb6c;
        cycles      = 0;
        cycle_limit = 0;
        step        = 0;
        clk         = 1'b0;
        rst         = 1'b1;
        rd_addr     = '0;
        drive_idle();

        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            abort_run("cannot open the stimulus file");
        end
        while (!$feof(fd)) begin
            code = $fgets(text, fd);
            if (code > 0) begin
                cycle_limit = cycle_limit + 4;
            end
        end
        cycle_limit = cycle_limit + 20;
        $fclose(fd);

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        #0.2;
        check_value("reset alloc_ok", 0, alloc_ok);
        check_value("reset full", 0, full);
        check_value("reset commit_en", 0, commit_en);
        check_value("reset store_go", 0, store_go);
        check_value("reset flush", 0, flush);

        fd = $fopen(STIM_FILE, "r");
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", cmd);
            if (code == 1 && cmd == "#") begin
                code = $fgets(text, fd);
            end else if (code == 1) begin
                code = $fscanf(fd, "%h %h %h %h %h", fld[0], fld[1], fld[2], fld[3], fld[4]);
                if (code != 5) begin
                    abort_run($sformatf("malformed stimulus line after step %0d", step));
                end
                step++;
                run_command();
            end
        end
        $fclose(fd);

        $display("All tests passed!");
        $finish;
    end

endmodule

//--- verif/rob_stim.txt
# command then five hex fields, unused ones 0; ops 0 alu, 1 store, 2 branch
# alloc rd op pred nick ok / exec nick data taken target / sdone nick
# chk_commit en nick data / chk_flush flush target / chk_reg addr data busy tag
chk_reg 1 0 0 0 0
chk_reg 1f 0 0 0 0
# in-order commit and rename tags
alloc 1 0 0 1 1
alloc 2 0 0 2 1
alloc 1 0 0 3 1
chk_reg 1 0 1 3 0
chk_reg 2 0 1 2 0
exec 3 33 0 0 0
chk_commit 0 0 0 0 0
exec 1 11 0 0 0
chk_commit 1 1 11 0 0
exec 2 22 0 0 0
chk_commit 1 2 22 0 0
chk_reg 1 11 1 3 0
idle 0 0 0 0 0
chk_commit 1 3 33 0 0
chk_reg 2 22 0 0 0
idle 0 0 0 0 0
chk_commit 0 0 0 0 0
chk_reg 1 33 0 0 0
# store at the head blocks a finished alu entry
alloc 0 1 0 4 1
alloc 3 0 0 5 1
exec 5 55 0 0 0
chk_commit 0 0 0 0 0
chk_reg 3 0 1 5 0
sdone 4 0 0 0 0
chk_commit 1 5 55 0 0
idle 0 0 0 0 0
chk_reg 3 55 0 0 0
# branch predicted not taken, resolves taken
alloc 4 2 0 6 1
alloc 5 0 0 7 1
exec 7 77 0 0 0
chk_flush 0 0 0 0 0
exec 6 600 1 1000 0
chk_flush 1 1000 0 0 0
chk_commit 1 6 600 0 0
chk_reg 5 0 1 7 0
idle 0 0 0 0 0
chk_flush 0 0 0 0 0
chk_commit 0 0 0 0 0
chk_reg 4 600 0 0 0
chk_reg 5 0 0 0 0
# fill all seven entries, then wrap
alloc 6 0 0 1 1
alloc 7 0 0 2 1
alloc 8 0 0 3 1
alloc 9 0 0 4 1
alloc a 0 0 5 1
alloc b 0 0 6 1
alloc c 0 0 7 1
alloc d 0 0 1 0
exec 1 1234 0 0 0
chk_commit 1 1 1234 0 0
idle 0 0 0 0 0
alloc d 0 0 1 1
chk_reg d 0 1 1 0
chk_reg 6 1234 0 0 0

//--- list.f
common/rob_pkg.sv
rob/rob.sv
source/rename_regfile.sv
source/rob_top.sv
verif/tb_rob_top.sv
